// File: src/tetris_pkg.sv
package tetris_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // playfield geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int ROWS = 22;
  localparam int COLS = 10;

  // reference cell of a freshly spawned piece frame
  localparam logic        [4:0] SPAWN_ROW = 5'd0;
  localparam logic signed [3:0] SPAWN_COL = 4'sd3;

  // cell colours, zero is an empty cell
  typedef enum logic [2:0] {
    CL_NONE,
    CL_CYAN,
    CL_YELLOW,
    CL_PURPLE,
    CL_GREEN,
    CL_RED,
    CL_BLUE,
    CL_ORANGE
  } color_t;

  typedef color_t [COLS-1:0] row_t;
  typedef row_t   [ROWS-1:0] grid_t;

  ////////////////////////////////////////////////////////////////////////////
  // pieces
  ////////////////////////////////////////////////////////////////////////////

  // 4x4 occupancy, [row][col] with row 0 on top and col 0 on the left
  typedef logic [0:3][0:3] shape_t;

  // order I, O, T, S, Z, J, L; shape k is drawn in colour k+1
  localparam shape_t SHAPE_TABLE [0:6] = '{
    16'b1111_0000_0000_0000,
    16'b0110_0110_0000_0000,
    16'b1110_0100_0000_0000,
    16'b0110_1100_0000_0000,
    16'b1100_0110_0000_0000,
    16'b1000_1110_0000_0000,
    16'b0010_1110_0000_0000
  };

  typedef enum logic [1:0] {
    MV_RIGHT,
    MV_LEFT,
    MV_DOWN,
    MV_NONE
  } move_t;

  // pieces only move down from row 0, so row stays unsigned
  typedef struct packed {
    shape_t             shape;
    color_t             color;
    logic        [4:0]  row;
    logic signed [3:0]  col;
  } piece_t;

  typedef enum logic [2:0] {
    IDLE,
    SPAWN,
    PLAY,
    CHECK,
    LOCK,
    CLEAR,
    GAME_OVER
  } game_state_t;

  // collision answer, returned with the candidate it was computed for
  typedef struct packed {
    logic   valid;
    logic   fits;
    piece_t cand;
    move_t  move;
  } fit_t;

endpackage

// File: src/piece_source.sv
`timescale 1ns/1ps

module piece_source import tetris_pkg::*; #(
  parameter int SEQ_LEN = 7
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   next_i,
  input  logic   restart_i,
  output shape_t shape_o,
  output color_t color_o
);

  // last index before wrapping back to the I piece
  localparam logic [2:0] LAST_IDX = 3'(SEQ_LEN - 1);

  logic [2:0] idx;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx <= 3'd0;
    end else if (restart_i) begin
      idx <= 3'd0;
    end else if (next_i) begin
      if (idx == LAST_IDX) begin
        idx <= 3'd0;
      end else begin
        idx <= idx + 3'd1;
      end
    end
  end

  // shape k is drawn in colour k+1
  assign shape_o = SHAPE_TABLE[idx];
  assign color_o = color_t'(idx + 3'd1);

endmodule

// File: src/move_request.sv
`timescale 1ns/1ps

module move_request import tetris_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  step_i,
  input  logic  right_i,
  input  logic  left_i,
  input  logic  ready_i,
  output move_t move_o,
  output logic  move_valid_o
);

  move_t pick;
  logic  accept;

  // right beats left, no button means down
  always_comb begin
    if (right_i) begin
      pick = MV_RIGHT;
    end else if (left_i) begin
      pick = MV_LEFT;
    end else begin
      pick = MV_DOWN;
    end
  end

  // steps while control is busy are simply dropped
  assign accept = step_i && ready_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      move_valid_o <= 1'b0;
    end else begin
      move_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      move_o <= pick;
    end
  end

endmodule

// File: src/collision_check.sv
`timescale 1ns/1ps

module collision_check import tetris_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  piece_t cand_i,
  input  move_t  move_i,
  input  logic   cand_valid_i,
  input  grid_t  grid_i,
  output fit_t   fit_o
);

  logic   fits;
  logic   valid_q;
  logic   fits_q;
  piece_t cand_q;
  move_t  move_q;

  ////////////////////////////////////////////////////////////////////////////
  // frame test
  ////////////////////////////////////////////////////////////////////////////

  // every occupied frame cell must land inside the walls and on an empty cell
  always_comb begin
    int gr;
    int gc;
    fits = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        gr = int'(cand_i.row) + r;
        gc = int'(cand_i.col) + c;
        if (cand_i.shape[r][c]) begin
          if (gr >= ROWS || gc < 0 || gc >= COLS) begin
            fits = 1'b0;
          end else if (grid_i[gr][gc] != CL_NONE) begin
            fits = 1'b0;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registered answer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= cand_valid_i;
    end
  end

  // candidate travels with its answer
  always_ff @(posedge clk) begin
    if (cand_valid_i) begin
      fits_q <= fits;
      cand_q <= cand_i;
      move_q <= move_i;
    end
  end

  assign fit_o = '{valid: valid_q, fits: fits_q, cand: cand_q, move: move_q};

endmodule

// File: src/game_control.sv
`timescale 1ns/1ps

module game_control import tetris_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        en_i,
  input  move_t       move_i,
  input  logic        move_valid_i,
  input  fit_t        fit_i,
  input  logic        busy_i,
  input  shape_t      shape_i,
  input  color_t      color_i,
  output piece_t      cand_o,
  output move_t       cand_move_o,
  output logic        cand_valid_o,
  output piece_t      active_o,
  output logic        lock_o,
  output logic        next_o,
  output logic        ready_o,
  output logic        clear_grid_o,
  output game_state_t state_o
);

  game_state_t state;
  piece_t      move_cand;
  piece_t      spawn_piece;

  // candidate for the requested move
  // col 7 + 1 wraps to -8, which sits off the left wall and never fits
  always_comb begin
    move_cand = active_o;
    case (move_i)
      MV_RIGHT: move_cand.col = active_o.col + 4'sd1;
      MV_LEFT:  move_cand.col = active_o.col - 4'sd1;
      MV_DOWN:  move_cand.row = active_o.row + 5'd1;
      default:  move_cand = active_o;
    endcase
  end

  assign spawn_piece = '{shape: shape_i, color: color_i, row: SPAWN_ROW, col: SPAWN_COL};

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= IDLE;
      cand_valid_o <= 1'b0;
      lock_o       <= 1'b0;
      next_o       <= 1'b0;
    end else begin
      cand_valid_o <= 1'b0;
      lock_o       <= 1'b0;
      next_o       <= 1'b0;
      case (state)
        IDLE: begin
          if (en_i) begin
            state <= SPAWN;
          end
        end
        SPAWN: begin
          cand_valid_o <= 1'b1;
          next_o       <= 1'b1;
          state        <= CHECK;
        end
        PLAY: begin
          if (move_valid_i) begin
            cand_valid_o <= 1'b1;
            state        <= CHECK;
          end
        end
        CHECK: begin
          if (fit_i.valid) begin
            if (fit_i.fits) begin
              state <= PLAY;
            end else if (fit_i.move == MV_NONE) begin
              // spawn blocked by the stack
              state <= GAME_OVER;
            end else if (fit_i.move == MV_DOWN) begin
              lock_o <= 1'b1;
              state  <= LOCK;
            end else begin
              state <= PLAY;
            end
          end
        end
        // busy rises on the lock edge, so give it a cycle
        LOCK: state <= CLEAR;
        CLEAR: begin
          if (!busy_i) begin
            state <= SPAWN;
          end
        end
        GAME_OVER: begin
          if (en_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SPAWN) begin
      cand_o      <= spawn_piece;
      cand_move_o <= MV_NONE;
    end else if (state == PLAY && move_valid_i) begin
      cand_o      <= move_cand;
      cand_move_o <= move_i;
    end
    if (state == CHECK && fit_i.valid && fit_i.fits) begin
      active_o <= fit_i.cand;
    end
  end

  // one move in flight at a time
  assign ready_o      = (state == PLAY) && !move_valid_i;
  assign clear_grid_o = (state == GAME_OVER) && en_i;
  assign state_o      = state;

endmodule

// File: src/grid_commit.sv
`timescale 1ns/1ps

module grid_commit import tetris_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       lock_i,
  input  piece_t     piece_i,
  input  piece_t     active_i,
  input  logic       clear_grid_i,
  input  logic       show_active_i,
  output grid_t      grid_o,
  output grid_t      stored_o,
  output logic       busy_o,
  output logic [7:0] lines_o
);

  grid_t      stored;
  logic       clr_found;
  logic [4:0] clr_row;

  // draw a piece over a grid, cells outside the field are skipped
  function automatic grid_t paint(grid_t g, piece_t p);
    grid_t res;
    int    gr;
    int    gc;
    res = g;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        gr = int'(p.row) + r;
        gc = int'(p.col) + c;
        if (p.shape[r][c] && gr < ROWS && gc >= 0 && gc < COLS) begin
          res[gr][gc] = p.color;
        end
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // full row search
  ////////////////////////////////////////////////////////////////////////////

  // lowest full row wins, later loop passes overwrite earlier ones
  always_comb begin
    logic full;
    clr_found = 1'b0;
    clr_row   = 5'd0;
    for (int r = 0; r < ROWS; r++) begin
      full = 1'b1;
      for (int c = 0; c < COLS; c++) begin
        if (stored[r][c] == CL_NONE) begin
          full = 1'b0;
        end
      end
      if (full) begin
        clr_found = 1'b1;
        clr_row   = 5'(r);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stored grid, lock and clear
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stored  <= grid_t'(0);
      busy_o  <= 1'b0;
      lines_o <= 8'd0;
    end else if (clear_grid_i) begin
      stored  <= grid_t'(0);
      busy_o  <= 1'b0;
      lines_o <= 8'd0;
    end else if (lock_i) begin
      stored <= paint(stored, piece_i);
      busy_o <= 1'b1;
    end else if (busy_o) begin
      if (clr_found) begin
        // rows above the full one drop by one
        for (int r = ROWS - 1; r > 0; r--) begin
          if (5'(r) <= clr_row) begin
            stored[r] <= stored[r-1];
          end
        end
        stored[0] <= row_t'(0);
        lines_o   <= lines_o + 8'd1;
      end else begin
        busy_o <= 1'b0;
      end
    end
  end

  assign stored_o = stored;
  assign grid_o   = show_active_i ? paint(stored, active_i) : stored;

endmodule

// File: src/tetris_top.sv
`timescale 1ns/1ps

module tetris_top import tetris_pkg::*; #(
  parameter int SEQ_LEN = 7
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        en_i,
  input  logic        step_i,
  input  logic        right_i,
  input  logic        left_i,
  output grid_t       grid_o,
  output game_state_t state_o,
  output logic        ready_o,
  output logic        lock_o,
  output logic [7:0]  lines_o
);

  move_t  move;
  logic   move_valid;
  piece_t cand;
  move_t  cand_move;
  logic   cand_valid;
  fit_t   fit;
  piece_t active;
  logic   busy;
  logic   next;
  logic   clear_grid;
  logic   show_active;
  shape_t shape;
  color_t color;
  grid_t  stored;

  // the moving piece is drawn until its lock lands in the stored grid
  assign show_active = (state_o == PLAY) || (state_o == CHECK) || (state_o == LOCK);

  ////////////////////////////////////////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  move_request i_move_request (
    .clk(clk), .rst(rst), .step_i(step_i), .right_i(right_i), .left_i(left_i),
    .ready_i(ready_o), .move_o(move), .move_valid_o(move_valid)
  );

  collision_check i_collision_check (
    .clk(clk), .rst(rst), .cand_i(cand), .move_i(cand_move),
    .cand_valid_i(cand_valid), .grid_i(stored), .fit_o(fit)
  );

  game_control i_game_control (
    .clk(clk), .rst(rst), .en_i(en_i), .move_i(move), .move_valid_i(move_valid),
    .fit_i(fit), .busy_i(busy), .shape_i(shape), .color_i(color),
    .cand_o(cand), .cand_move_o(cand_move), .cand_valid_o(cand_valid),
    .active_o(active), .lock_o(lock_o), .next_o(next), .ready_o(ready_o),
    .clear_grid_o(clear_grid), .state_o(state_o)
  );

  grid_commit i_grid_commit (
    .clk(clk), .rst(rst), .lock_i(lock_o), .piece_i(active), .active_i(active),
    .clear_grid_i(clear_grid), .show_active_i(show_active), .grid_o(grid_o),
    .stored_o(stored), .busy_o(busy), .lines_o(lines_o)
  );

  piece_source #(.SEQ_LEN(SEQ_LEN)) i_piece_source (
    .clk(clk), .rst(rst), .next_i(next), .restart_i(clear_grid),
    .shape_o(shape), .color_o(color)
  );

endmodule

// File: verification/tetris_checker.sv
`timescale 1ns/1ps

module tetris_checker import tetris_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        lock_i,
  input logic        next_i,
  input logic        ready_i,
  input game_state_t state_i,
  input logic        cand_valid_i,
  input fit_t        fit_i
);

  // lock and next are single-cycle strobes
  lock_pulse: assert property (@(posedge clk) disable iff (rst) lock_i |=> !lock_i)
    else $error("lock_o stayed high for more than one cycle");

  next_pulse: assert property (@(posedge clk) disable iff (rst) next_i |=> !next_i)
    else $error("next_o stayed high for more than one cycle");

  // ready only in play, with no candidate or answer still on its way
  ready_in_play: assert property (@(posedge clk) disable iff (rst)
    ready_i |-> state_i == PLAY && !cand_valid_i && !fit_i.valid)
    else $error("ready_o high outside PLAY or with a move in flight");

  // the fit answer follows one cycle later, with no second candidate in between
  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    cand_valid_i |=> fit_i.valid && !cand_valid_i)
    else $error("candidate raised again before its fit answer");

endmodule

// File: verification/tetris_tb.sv
`timescale 1ns/1ps

module tetris_tb import tetris_pkg::*; ();

  localparam int SEQ_LEN    = 7;
  localparam int STEPS      = 2000;
  localparam int MAX_CYCLES = STEPS * 40;

  logic        clk;
  logic        rst;
  logic        en_i;
  logic        step_i;
  logic        right_i;
  logic        left_i;
  grid_t       grid_o;
  game_state_t state_o;
  logic        ready_o;
  logic        lock_o;
  logic [7:0]  lines_o;

  int errors;
  int checks;
  int games;
  int cycle_count;

  // model state: stored grid, active piece and sequence position
  grid_t m_grid;
  int    m_shape;
  int    m_idx;
  int    m_row;
  int    m_col;
  int    m_target;
  int    m_lines;
  bit    m_over;

  tetris_top #(.SEQ_LEN(SEQ_LEN)) i_tetris_top (
    .clk(clk), .rst(rst), .en_i(en_i), .step_i(step_i), .right_i(right_i),
    .left_i(left_i), .grid_o(grid_o), .state_o(state_o), .ready_o(ready_o),
    .lock_o(lock_o), .lines_o(lines_o)
  );

  bind game_control tetris_checker i_tetris_checker (
    .clk(clk), .rst(rst), .lock_i(lock_o), .next_i(next_o), .ready_i(ready_o),
    .state_i(state_o), .cand_valid_i(cand_valid_o), .fit_i(fit_i)
  );

  always #20 clk = ~clk;

  // worst case of 40 cycles per step
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check(input logic [$bits(grid_t)-1:0] got,
                       input logic [$bits(grid_t)-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit piece_fits(grid_t g, int s, int row, int col);
    bit ok;
    ok = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (SHAPE_TABLE[s][r][c]) begin
          if (row + r >= ROWS || col + c < 0 || col + c >= COLS) begin
            ok = 1'b0;
          end else if (g[row + r][col + c] != CL_NONE) begin
            ok = 1'b0;
          end
        end
      end
    end
    return ok;
  endfunction

  function automatic grid_t draw_piece(grid_t g, int s, int row, int col);
    grid_t res;
    res = g;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (SHAPE_TABLE[s][r][c]) begin
          res[row + r][col + c] = color_t'(s + 1);
        end
      end
    end
    return res;
  endfunction

  function automatic grid_t expected_grid();
    if (m_over) begin
      return m_grid;
    end
    return draw_piece(m_grid, m_shape, m_row, m_col);
  endfunction

  // keep the rows that are not full, packed down from the floor
  task automatic drop_full_rows();
    grid_t src;
    int    dst;
    bit    full;
    src    = m_grid;
    m_grid = grid_t'(0);
    dst    = ROWS - 1;
    for (int r = ROWS - 1; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < COLS; c++) begin
        if (src[r][c] == CL_NONE) begin
          full = 1'b0;
        end
      end
      if (full) begin
        m_lines++;
      end else begin
        m_grid[dst] = src[r];
        dst--;
      end
    end
  endtask

  task automatic spawn_next();
    m_shape  = m_idx;
    m_idx    = (m_idx + 1) % SEQ_LEN;
    m_row    = int'(SPAWN_ROW);
    m_col    = int'(SPAWN_COL);
    m_target = int'($urandom_range(9, 0)) - 1;
    m_over   = !piece_fits(m_grid, m_shape, m_row, m_col);
  endtask

  task automatic apply_move(input bit r, input bit l, output bit locked);
    locked = 1'b0;
    if (r || l) begin
      // right wins when both buttons are down
      if (piece_fits(m_grid, m_shape, m_row, m_col + (r ? 1 : -1))) begin
        m_col = m_col + (r ? 1 : -1);
      end else begin
        m_target = m_col;
      end
    end else if (piece_fits(m_grid, m_shape, m_row + 1, m_col)) begin
      m_row++;
    end else begin
      locked = 1'b1;
      m_grid = draw_piece(m_grid, m_shape, m_row, m_col);
      drop_full_rows();
      spawn_next();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // wait for ready or game over, stray steps only while the move is surely in flight
  task automatic settle(input bit stray, output int cycles, output int locks);
    cycles = 0;
    locks  = 0;
    forever begin
      @(negedge clk);
      if (lock_o) begin
        locks++;
      end
      if (ready_o || state_o == GAME_OVER) begin
        break;
      end
      cycles++;
      @(posedge clk);
      if (stray && cycles < 3) begin
        step_i <= 1'($urandom_range(1, 0));
      end else begin
        step_i <= 1'b0;
      end
      right_i <= 1'($urandom_range(1, 0));
      left_i  <= 1'($urandom_range(1, 0));
    end
  endtask

  task automatic check_idle(input string when);
    check(state_o, IDLE, {"state ", when});
    check(grid_o, grid_t'(0), {"grid ", when});
    check(lines_o, 8'd0, {"line count ", when});
    check(ready_o, 1'b0, {"ready ", when});
  endtask

  task automatic start_game();
    int cycles;
    int locks;
    @(posedge clk);
    en_i <= 1'b1;
    @(posedge clk);
    en_i <= 1'b0;
    spawn_next();
    settle(1'b0, cycles, locks);
    games++;
    check(state_o, m_over ? GAME_OVER : PLAY, "state after start");
    check(grid_o, expected_grid(), "grid after start");
    // every game opens with the cyan I piece
    check(grid_o[0][3], CL_CYAN, "first piece at the spawn cell");
    check(grid_o[0][6], CL_CYAN, "first piece right end");
  endtask

  task automatic take_step();
    bit r;
    bit l;
    bit locked;
    int cycles;
    int locks;
    if ($urandom_range(3, 0) == 0) begin
      r = 1'($urandom_range(1, 0));
      l = 1'($urandom_range(1, 0));
    end else begin
      r = m_col < m_target;
      l = m_col > m_target;
    end
    @(posedge clk);
    step_i  <= 1'b1;
    right_i <= r;
    left_i  <= l;
    // accepted here
    @(posedge clk);
    step_i <= 1'($urandom_range(1, 0));
    apply_move(r, l, locked);
    settle(1'b1, cycles, locks);
    check(state_o, m_over ? GAME_OVER : PLAY, "state after step");
    check(grid_o, expected_grid(), "grid after step");
    check(lines_o, 8'(m_lines), "cleared line count");
    check(locks, locked ? 1 : 0, "lock pulses");
    if (!locked) begin
      check(cycles, 3, "cycles from accepted step to grid update");
    end
  endtask

  task automatic restart_game();
    grid_t frozen;
    frozen = grid_o;
    repeat (4) begin
      @(posedge clk);
      step_i  <= 1'b1;
      right_i <= 1'($urandom_range(1, 0));
      left_i  <= 1'($urandom_range(1, 0));
    end
    @(posedge clk);
    step_i <= 1'b0;
    @(negedge clk);
    check(state_o, GAME_OVER, "state while steps arrive after game over");
    check(grid_o, frozen, "grid while steps arrive after game over");
    @(posedge clk);
    en_i <= 1'b1;
    @(posedge clk);
    en_i <= 1'b0;
    @(negedge clk);
    check_idle("after return to idle");
    m_grid  = grid_t'(0);
    m_lines = 0;
    m_idx   = 0;
    start_game();
  endtask

  initial begin
    void'($urandom(15));
    clk     = 1'b0;
    rst     = 1'b1;
    en_i    = 1'b0;
    step_i  = 1'b0;
    right_i = 1'b0;
    left_i  = 1'b0;
    m_grid  = grid_t'(0);
    m_lines = 0;
    m_idx   = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle("after reset");
    check(lock_o, 1'b0, "lock pulse after reset");
    start_game();
    for (int n = 0; n < STEPS; n++) begin
      take_step();
      if (m_over) begin
        restart_game();
      end
    end
    $display("checks: %0d  errors: %0d  steps: %0d  games: %0d  cycles: %0d",
             checks, errors, STEPS, games, cycle_count);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
src/tetris_pkg.sv
src/piece_source.sv
src/move_request.sv
src/collision_check.sv
src/game_control.sv
src/grid_commit.sv
src/tetris_top.sv
verification/tetris_checker.sv
verification/tetris_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tetris_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
